// File: rtl/frame_pkg.sv
// shared types and constants for the frame store
// pixels are 8-bit grey and four of them pack into one 32-bit word
// lane 0 sits in the low byte and is the leftmost pixel on screen
// import with a wildcard in a module body, use scoped names in headers

package frame_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////////////////////

   localparam int PIX_W        = 8;
   localparam int PIX_PER_WORD = 4;
   localparam int WORD_W       = PIX_W * PIX_PER_WORD;
   localparam int ADDR_W       = 19;
   // raster counter width
   localparam int CNT_W        = 12;

   typedef logic [PIX_W-1:0]  pixel_t;
   typedef logic [WORD_W-1:0] word_t;
   typedef logic [ADDR_W-1:0] addr_t;

   ////////////////////////////////////////////////////////////////////////////
   // bundles
   ////////////////////////////////////////////////////////////////////////////

   // raster position plus sync and blank for that position
   typedef struct packed {
      logic [CNT_W-1:0] hcount;
      logic [CNT_W-1:0] vcount;
      logic             hsync;
      logic             vsync;
      logic             blank;
   } raster_t;

   // one memory cycle, we low means a read of addr
   typedef struct packed {
      logic  we;
      addr_t addr;
      word_t wdata;
   } mem_req_t;

   // host write of one full word
   typedef struct packed {
      addr_t addr;
      word_t data;
   } wr_req_t;

   // registered display output
   typedef struct packed {
      pixel_t pixel;
      logic   hsync;
      logic   vsync;
      logic   blank;
   } video_out_t;

   // values seen right after reset
   localparam raster_t RASTER_IDLE =
      '{hcount: '0, vcount: '0, hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
   localparam video_out_t VIDEO_IDLE =
      '{pixel: '0, hsync: 1'b0, vsync: 1'b0, blank: 1'b1};

endpackage

// File: rtl/video_timing.sv
// raster timing generator
// counts pixels across a line and lines down a frame
// sync pulses are active high, blank is high outside the active area

module video_timing #(
   parameter int H_ACTIVE = 32,
   parameter int H_FRONT  = 4,
   parameter int H_SYNC   = 4,
   parameter int H_BACK   = 8,
   parameter int V_ACTIVE = 8,
   parameter int V_FRONT  = 2,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 2
) (
   input  logic               clk,
   input  logic               arst_n,
   output frame_pkg::raster_t raster
);
   import frame_pkg::*;

   localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   // counter compare points
   localparam logic [CNT_W-1:0] H_LAST   = CNT_W'(H_TOTAL - 1);
   localparam logic [CNT_W-1:0] V_LAST   = CNT_W'(V_TOTAL - 1);
   localparam logic [CNT_W-1:0] H_END    = CNT_W'(H_ACTIVE);
   localparam logic [CNT_W-1:0] V_END    = CNT_W'(V_ACTIVE);
   localparam logic [CNT_W-1:0] HS_START = CNT_W'(H_ACTIVE + H_FRONT);
   localparam logic [CNT_W-1:0] HS_STOP  = CNT_W'(H_ACTIVE + H_FRONT + H_SYNC);
   localparam logic [CNT_W-1:0] VS_START = CNT_W'(V_ACTIVE + V_FRONT);
   localparam logic [CNT_W-1:0] VS_STOP  = CNT_W'(V_ACTIVE + V_FRONT + V_SYNC);

   logic [CNT_W-1:0] hcount;
   logic [CNT_W-1:0] vcount;

   // hcount wraps every line, vcount steps at the end of each line
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hcount <= '0;
         vcount <= '0;
      end else if (hcount == H_LAST) begin
         hcount <= '0;
         if (vcount == V_LAST) begin
            vcount <= '0;
         end else begin
            vcount <= vcount + CNT_W'(1);
         end
      end else begin
         hcount <= hcount + CNT_W'(1);
      end
   end

   // sync windows follow the front porch
   always_comb begin
      raster.hcount = hcount;
      raster.vcount = vcount;
      raster.hsync  = (hcount >= HS_START) && (hcount < HS_STOP);
      raster.vsync  = (vcount >= VS_START) && (vcount < VS_STOP);
      raster.blank  = (hcount >= H_END) || (vcount >= V_END);
   end

endmodule

// File: rtl/slot_scheduler.sv
// memory slot owner for the frame store
// every group of four pixel clocks gives a read slot at phase 0 and a
// write slot at phase 2, a clear takes every blank cycle instead
// host writes land in a single pending register until their slot

module slot_scheduler #(
   parameter int DEPTH = 64
) (
   input  logic                clk,
   input  logic                arst_n,
   input  frame_pkg::raster_t  raster,
   input  frame_pkg::addr_t    fetch_addr,
   input  logic                wr_strobe,
   input  frame_pkg::wr_req_t  wr_req,
   input  logic [5:0]          view_offset,
   output frame_pkg::mem_req_t mem_req,
   output logic                clear_busy
);
   import frame_pkg::*;

   localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);

   // pending host write
   wr_req_t    pend_q;
   logic       pend_valid;

   // clear sequencing
   logic [5:0] offset_q;
   addr_t      clear_addr;

   logic [1:0] phase;
   logic       offset_changed;
   logic       clear_slot;
   logic       write_slot;
   logic       read_slot;

   assign phase          = raster.hcount[1:0];
   assign offset_changed = view_offset != offset_q;

   // clear owns every blank cycle while busy
   assign clear_slot = clear_busy && raster.blank;
   // host write waits out a clear
   assign write_slot = !clear_busy && pend_valid && (phase == 2'd2);
   // no fetch while the frame is being wiped
   assign read_slot  = !clear_busy && (phase == 2'd0);

   ////////////////////////////////////////////////////////////////////////////
   // request mux
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      // idle cycles present address 0 with no write
      mem_req = '0;
      if (clear_slot) begin
         mem_req.we    = 1'b1;
         mem_req.addr  = clear_addr;
         mem_req.wdata = '0;
      end else if (write_slot) begin
         mem_req.we    = 1'b1;
         mem_req.addr  = pend_q.addr;
         mem_req.wdata = pend_q.data;
      end else if (read_slot) begin
         mem_req.addr  = fetch_addr;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // pending write
   ////////////////////////////////////////////////////////////////////////////

   // a new strobe always overwrites, even in its own commit cycle
   always_ff @(posedge clk) begin
      if (wr_strobe) begin
         pend_q <= wr_req;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pend_valid <= 1'b0;
      end else if (wr_strobe) begin
         pend_valid <= 1'b1;
      end else if (write_slot) begin
         pend_valid <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // clear sequence
   ////////////////////////////////////////////////////////////////////////////

   // any offset change restarts the wipe from word 0
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         offset_q   <= '0;
         clear_busy <= 1'b0;
         clear_addr <= '0;
      end else begin
         offset_q <= view_offset;
         if (offset_changed) begin
            clear_busy <= 1'b1;
            clear_addr <= '0;
         end else if (clear_slot) begin
            // last word written, hand slots back
            if (clear_addr == LAST_ADDR) begin
               clear_busy <= 1'b0;
            end
            clear_addr <= clear_addr + addr_t'(1);
         end
      end
   end

endmodule

// File: rtl/pixel_fetch.sv
// display side of the frame store
// asks for the word four pixels ahead at phase 0, catches it at phase 2
// and hands its lanes out one per clock in the following group
// a raster position reaches the video output 5 clocks later

module pixel_fetch #(
   parameter int H_ACTIVE = 32,
   parameter int H_TOTAL  = 48,
   parameter int V_TOTAL  = 14
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  frame_pkg::raster_t    raster,
   input  frame_pkg::word_t      rdata,
   output frame_pkg::addr_t      fetch_addr,
   output frame_pkg::video_out_t video
);
   import frame_pkg::*;

   // words per active line
   localparam int               WPL    = H_ACTIVE / PIX_PER_WORD;
   localparam logic [CNT_W-1:0] H_WRAP = CNT_W'(H_TOTAL - PIX_PER_WORD);
   localparam logic [CNT_W-1:0] V_LAST = CNT_W'(V_TOTAL - 1);

   logic [CNT_W-1:0] line_sel;
   logic [CNT_W-3:0] col_sel;

   // word capture chain
   word_t   word_q;
   word_t   disp_word;
   pixel_t  pix_q;

   // raster delayed by 1 to 4 clocks
   raster_t ras_d [4];

   ////////////////////////////////////////////////////////////////////////////
   // fetch address
   ////////////////////////////////////////////////////////////////////////////

   // last group of a line looks ahead to word 0 of the next line
   always_comb begin
      if (raster.hcount == H_WRAP) begin
         col_sel  = '0;
         line_sel = (raster.vcount == V_LAST) ? '0 : raster.vcount + CNT_W'(1);
      end else begin
         col_sel  = raster.hcount[CNT_W-1:2] + (CNT_W - 2)'(1);
         line_sel = raster.vcount;
      end
   end

   assign fetch_addr = addr_t'(line_sel) * addr_t'(WPL) + addr_t'(col_sel);

   ////////////////////////////////////////////////////////////////////////////
   // capture and lane select
   ////////////////////////////////////////////////////////////////////////////

   // read data is valid at phase 2, then held one more group for display
   always_ff @(posedge clk) begin
      if (raster.hcount[1:0] == 2'd2) begin
         word_q    <= rdata;
         disp_word <= word_q;
      end
      // lane follows the position three clocks back
      pix_q <= disp_word[ras_d[2].hcount[1:0] * PIX_W +: PIX_W];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 4; i++) begin
            ras_d[i] <= RASTER_IDLE;
         end
      end else begin
         ras_d[0] <= raster;
         for (int i = 1; i < 4; i++) begin
            ras_d[i] <= ras_d[i-1];
         end
      end
   end

   // output register, pixel forced to black in blanking
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         video <= VIDEO_IDLE;
      end else begin
         video.pixel <= ras_d[3].blank ? '0 : pix_q;
         video.hsync <= ras_d[3].hsync;
         video.vsync <= ras_d[3].vsync;
         video.blank <= ras_d[3].blank;
      end
   end

endmodule

// File: rtl/frame_ram.sv
// word-wide frame memory
// behaves like a pipelined synchronous SRAM with read data two clocks
// after the request, a write cycle returns the old contents
// addresses past the end read as zero and ignore writes

module frame_ram #(
   parameter int DEPTH = 64
) (
   input  logic                clk,
   input  frame_pkg::mem_req_t mem_req,
   output frame_pkg::word_t    rdata
);
   import frame_pkg::*;

   localparam int IDX_W = $clog2(DEPTH);

   word_t             mem [DEPTH];
   word_t             rd_s1;
   logic [IDX_W-1:0]  idx;
   logic              in_range;

   assign idx      = mem_req.addr[IDX_W-1:0];
   assign in_range = mem_req.addr < addr_t'(DEPTH);

   ////////////////////////////////////////////////////////////////////////////
   // array and output pipeline
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (mem_req.we && in_range) begin
         mem[idx] <= mem_req.wdata;
      end
   end

   // first stage samples the array, second drives the bus
   always_ff @(posedge clk) begin
      if (in_range) begin
         rd_s1 <= mem[idx];
      end else begin
         rd_s1 <= '0;
      end
      rdata <= rd_s1;
   end

endmodule

// File: rtl/frame_store_top.sv
// frame store top level
// raster timing drives both the slot scheduler and the display fetch
// host writes and clears share the single memory with display reads
// raster sizes are set here and passed down

module frame_store_top #(
   parameter int H_ACTIVE = 32,
   parameter int H_FRONT  = 4,
   parameter int H_SYNC   = 4,
   parameter int H_BACK   = 8,
   parameter int V_ACTIVE = 8,
   parameter int V_FRONT  = 2,
   parameter int V_SYNC   = 2,
   parameter int V_BACK   = 2
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  wr_strobe,
   input  frame_pkg::wr_req_t    wr_req,
   input  logic [5:0]            view_offset,
   output frame_pkg::video_out_t video,
   output logic                  clear_busy
);
   import frame_pkg::*;

   localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   // one word per four active pixels
   localparam int DEPTH   = (H_ACTIVE / PIX_PER_WORD) * V_ACTIVE;

   raster_t  raster;
   addr_t    fetch_addr;
   mem_req_t mem_req;
   word_t    rdata;

   video_timing #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) u_video_timing (
      .clk    (clk),
      .arst_n (arst_n),
      .raster (raster)
   );

   slot_scheduler #(.DEPTH(DEPTH)) u_slot_scheduler (
      .clk         (clk),
      .arst_n      (arst_n),
      .raster      (raster),
      .fetch_addr  (fetch_addr),
      .wr_strobe   (wr_strobe),
      .wr_req      (wr_req),
      .view_offset (view_offset),
      .mem_req     (mem_req),
      .clear_busy  (clear_busy)
   );

   pixel_fetch #(
      .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)
   ) u_pixel_fetch (
      .clk        (clk),
      .arst_n     (arst_n),
      .raster     (raster),
      .rdata      (rdata),
      .fetch_addr (fetch_addr),
      .video      (video)
   );

   frame_ram #(.DEPTH(DEPTH)) u_frame_ram (
      .clk     (clk),
      .mem_req (mem_req),
      .rdata   (rdata)
   );

endmodule

// File: testbench/frame_store_props.sv
// concurrent checks on memory slot use and the clear sequence
// bound into the frame store top level, reports through its assertions

module frame_store_props (
   input logic                clk,
   input logic                arst_n,
   input frame_pkg::raster_t  raster,
   input frame_pkg::mem_req_t mem_req,
   input logic [5:0]          view_offset,
   input logic                clear_busy
);
   timeunit 1ns;
   timeprecision 100ps;

   // in the active area only the phase 2 host slot may write
   write_in_slot: assert property (
      @(posedge clk) disable iff (!arst_n)
      (mem_req.we && !raster.blank) |-> (raster.hcount[1:0] == 2'd2)
   ) else $error("memory write in the active area outside phase 2");

   // during a clear every cycle without a write is idle at address 0
   no_read_in_clear: assert property (
      @(posedge clk) disable iff (!arst_n)
      (clear_busy && !mem_req.we) |-> (mem_req.addr == '0)
   ) else $error("fetch read issued while a clear is running");

   // an offset change raises busy one clock later
   busy_after_change: assert property (
      @(posedge clk) disable iff (!arst_n)
      (view_offset != $past(view_offset)) |=> clear_busy
   ) else $error("clear_busy not raised after a view offset change");

endmodule

bind frame_store_top frame_store_props u_frame_store_props (
   .clk         (clk),
   .arst_n      (arst_n),
   .raster      (raster),
   .mem_req     (mem_req),
   .view_offset (view_offset),
   .clear_busy  (clear_busy)
);

// File: testbench/tb_frame_store.sv
// testbench for the frame store top level
// drives seeded random host writes and view offset changes, keeps a word
// model of the frame and follows the display through its sync edges
// built and run from the Makefile, which searches the log for the result

module tb_frame_store;
   timeunit 1ns;
   timeprecision 100ps;
   import frame_pkg::*;

   // default raster of the top level, 48 clocks by 14 lines
   localparam int H_ACTIVE = 32;
   localparam int H_SYNC   = 4;
   localparam int V_ACTIVE = 8;
   localparam int V_SYNC   = 2;
   localparam int WPL      = H_ACTIVE / PIX_PER_WORD;
   localparam int DEPTH    = WPL * V_ACTIVE;
   localparam int IDX_W    = $clog2(DEPTH);
   // three frames of clocks
   localparam int TIMEOUT  = 3 * 48 * 14;

   logic       clk = 1'b0;
   logic       arst_n;
   logic       wr_strobe;
   wr_req_t    wr_req;
   logic [5:0] view_offset;
   video_out_t video;
   logic       clear_busy;

   integer     seed = 32'hfbfc_9b26;
   // expected frame, one entry per memory word
   word_t      model_mem [DEPTH];
   wr_req_t    req;
   int         n_errors = 0;
   int         test_errors = 0;
   int         n_tests = 0;
   int         n_failed = 0;
   bit         timed_out = 1'b0;

   frame_store_top u_frame_store_top (
      .clk         (clk),
      .arst_n      (arst_n),
      .wr_strobe   (wr_strobe),
      .wr_req      (wr_req),
      .view_offset (view_offset),
      .video       (video),
      .clear_busy  (clear_busy)
   );

   always #2 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // cycle and wait helpers
   ////////////////////////////////////////////////////////////////////////////

   // outputs are settled and inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // one clock of a bounded wait, flags a timeout once the budget is spent
   task automatic bounded_step(inout int n, input string what);
      if (n >= TIMEOUT) begin
         $display("timeout while waiting for %s", what);
         timed_out = 1'b1;
         n_errors++;
      end else begin
         next_cycle();
         n++;
      end
   endtask

   // on_busy picks clear_busy, otherwise video.vsync
   task automatic wait_level(input bit on_busy, input logic level, input string what);
      int n = 0;
      while (!timed_out && ((on_busy ? clear_busy : video.vsync) !== level)) begin
         bounded_step(n, what);
      end
   endtask

   task automatic expect_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAIL %s: got %h expected %h", name, got, exp);
         n_errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   function automatic wr_req_t rand_req();
      wr_req_t r;
      r.addr = addr_t'($unsigned($random(seed)) % DEPTH);
      r.data = $random(seed);
      return r;
   endfunction

   // one strobe, then a random gap so strobes land 4 to 7 clocks apart
   task automatic host_write(input wr_req_t w);
      wr_req    = w;
      wr_strobe = 1'b1;
      next_cycle();
      wr_strobe = 1'b0;
      repeat (3 + $unsigned($random(seed)) % 4) begin
         next_cycle();
      end
   endtask

   // step the offset to any other value, busy must follow one clock later
   task automatic start_clear();
      view_offset = view_offset + 6'(1 + $unsigned($random(seed)) % 63);
      next_cycle();
      expect_value("clear_busy", 32'(clear_busy), 32'd1);
      foreach (model_mem[i]) begin
         model_mem[i] = '0;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // display checks
   ////////////////////////////////////////////////////////////////////////////

   // next full frame after a vsync pulse, pixel k of the frame is taken
   // from lane h mod 4 of word v*WPL + h/4
   task automatic check_frame();
      int    n = 0;
      int    k = 0;
      int    h;
      int    v;
      word_t w;
      wait_level(1'b0, 1'b0, "vsync low");
      wait_level(1'b0, 1'b1, "vsync start");
      wait_level(1'b0, 1'b0, "vsync end");
      while (!timed_out && k < H_ACTIVE * V_ACTIVE) begin
         bounded_step(n, "active pixels");
         if (!video.blank) begin
            h = k % H_ACTIVE;
            v = k / H_ACTIVE;
            w = model_mem[IDX_W'(v * WPL + h / 4)];
            expect_value($sformatf("video.pixel x%0d y%0d", h, v), 32'(video.pixel),
                         32'(pixel_t'(w >> ((h % 4) * PIX_W))));
            k++;
         end
      end
   endtask

   // line and frame shape over two frames, counted between sync edges
   task automatic check_raster();
      int   n = 0;
      int   frames = 0;
      int   line_pix = 0;
      int   hs_len = 0;
      int   vs_lines = 0;
      int   act_lines = 0;
      logic hs_prev = 1'b0;
      logic vs_prev = 1'b1;
      wait_level(1'b0, 1'b0, "vsync low");
      wait_level(1'b0, 1'b1, "vsync start");
      while (!timed_out && frames < 2) begin
         bounded_step(n, "two frames of raster");
         line_pix += int'(!video.blank);
         hs_len   += int'(video.hsync);
         // a line closes at the rising edge of its hsync
         if (video.hsync && !hs_prev) begin
            if (line_pix != 0) begin
               expect_value("video.blank low clocks per line", line_pix, H_ACTIVE);
               act_lines++;
            end
            line_pix = 0;
            vs_lines += int'(video.vsync);
         end
         if (!video.hsync && hs_prev) begin
            expect_value("video.hsync length", hs_len, H_SYNC);
            hs_len = 0;
         end
         if (!video.vsync && vs_prev) begin
            expect_value("video.vsync lines", vs_lines, V_SYNC);
            vs_lines = 0;
         end
         if (video.vsync && !vs_prev) begin
            expect_value("active lines per frame", act_lines, V_ACTIVE);
            act_lines = 0;
            frames++;
         end
         hs_prev = video.hsync;
         vs_prev = video.vsync;
      end
   endtask

   task automatic end_test(input string name);
      n_tests++;
      if (n_errors == test_errors) begin
         $display("test %0d %s: ok", n_tests, name);
      end else begin
         n_failed++;
         $display("test %0d %s: %0d errors", n_tests, name, n_errors - test_errors);
      end
      test_errors = n_errors;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      arst_n      = 1'b0;
      wr_strobe   = 1'b0;
      wr_req      = '0;
      view_offset = '0;
      repeat (3) begin
         @(posedge clk);
      end
      #1;
      arst_n = 1'b1;

      expect_value("clear_busy", 32'(clear_busy), 32'd0);
      expect_value("video", 32'(video),
                   32'(video_out_t'{pixel: '0, hsync: 1'b0, vsync: 1'b0, blank: 1'b1}));
      end_test("reset state");

      check_raster();
      end_test("raster shape");

      // first clear gives the memory known contents
      start_clear();
      wait_level(1'b1, 1'b0, "end of first clear");
      repeat (40) begin
         req = rand_req();
         host_write(req);
         model_mem[IDX_W'(req.addr)] = req.data;
      end
      check_frame();
      end_test("write and display");

      start_clear();
      wait_level(1'b1, 1'b0, "end of clear");
      check_frame();
      end_test("clear");

      // words for the next wipe to remove
      repeat (8) begin
         req = rand_req();
         host_write(req);
         model_mem[IDX_W'(req.addr)] = req.data;
      end

      // strobes during the wipe, only the last one is pending at its end
      start_clear();
      repeat (3) begin
         expect_value("clear_busy", 32'(clear_busy), 32'd1);
         req = rand_req();
         host_write(req);
      end
      wait_level(1'b1, 1'b0, "end of clear with held writes");
      model_mem[IDX_W'(req.addr)] = req.data;
      check_frame();
      end_test("writes during clear");

      $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, n_errors);
      if (n_errors == 0 && !timed_out) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: compile.f
rtl/frame_pkg.sv
rtl/video_timing.sv
rtl/slot_scheduler.sv
rtl/pixel_fetch.sv
rtl/frame_ram.sv
rtl/frame_store_top.sv
testbench/frame_store_props.sv
testbench/tb_frame_store.sv

// File: Makefile
# Verilator flow for the frame store testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_frame_store
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the result comes from the log, not from the simulator exit code
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
